// File: filelist.f
+incdir+tests
verilog/spram_pkg.sv
verilog/spram_port_ctrl.sv
verilog/spram_array.sv
verilog/spram_out_pipe.sv
verilog/spram_top.sv
tests/tb_spram.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs tb_spram with Verilator once for each write mode.
# Exits non-zero unless every run reports a pass.

cd "$(dirname "$0")" || exit 1

status=0
for mode in 0 1 2; do
    build_dir="obj_dir_mode${mode}"
    verilator --binary --timing --assert -j 0 \
        --top-module tb_spram -Gtb_write_mode=${mode} \
        --Mdir "${build_dir}" -f filelist.f \
        && "./${build_dir}/Vtb_spram" | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
        && echo "write mode ${mode}: run passed" \
        || { echo "write mode ${mode}: run failed"; status=1; }
done

exit ${status}

// File: tests/spram_model.svh
// ----------------------------------------------------------
// Reference memory for tb_spram. Tracks the stored words and
// the three read stages at latency 3, plus the douta check.
// Included inside the testbench module body.
// ----------------------------------------------------------

`ifndef SPRAM_MODEL_SVH
`define SPRAM_MODEL_SVH

// Shadow of the stored words, starts at zero like the RAM
data_t model_mem [mem_depth] = '{default: '0};

data_t model_rd;                                           // First read register
data_t model_mid;                                          // Free-running stage
data_t model_out;                                          // Final stage, expected douta

// Old word with the masked lanes replaced by the new word
function automatic data_t merge_lanes(data_t old_word, data_t new_word, lane_mask_t mask);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < num_lanes; i++) begin
        if (mask[i]) begin
            merged[i*byte_width +: byte_width] = new_word[i*byte_width +: byte_width];
        end
    end
    return merged;
endfunction

// Read stages return to zero, stored words stay
task automatic model_reset();
    model_rd  = '0;
    model_mid = '0;
    model_out = '0;
endtask

// One rising edge with the given port inputs
task automatic model_edge(input logic en, input addr_t a, input data_t d,
                          input lane_mask_t we, input logic ce);
    data_t old_word;
    old_word = model_mem[a];
    if (ce) begin
        model_out = model_mid;
    end
    model_mid = model_rd;
    if (en) begin
        if (tb_write_mode == 1) begin
            model_rd = merge_lanes(old_word, d, we);       // Write-first
        end else if ((tb_write_mode == 0) || (we == '0)) begin
            model_rd = old_word;                           // No-change holds while writing
        end
        model_mem[a] = merge_lanes(old_word, d, we);
    end
endtask

// Compares one output word, stops the run on a mismatch
task automatic check_word(input string test_name, input data_t expected, input data_t actual);
    assert (actual === expected)
        else begin
            $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "%s: douta mismatch", test_name);
        end
endtask

`endif

// File: tests/tb_spram.sv
// ----------------------------------------------------------
// Directed testbench for spram_top at read latency 3. The
// write mode is picked by tb_write_mode (0, 1 or 2).
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_spram #(
    parameter int tb_write_mode = 0
);

    import spram_pkg::*;

    localparam int tb_latency     = 3;
    localparam int num_lane_words = 16;
    // Approximate length of all tests in cycles
    localparam int test_cycles    = 3 + 4 + 5 * num_lane_words + 16 + 14 + 18 + 24;
    localparam int timeout_cycles = 12 * test_cycles;

    localparam write_mode_e dut_mode = write_mode_e'(tb_write_mode);

    logic       clka;
    logic       rsta;
    logic       ena;
    addr_t      addra;
    data_t      dina;
    lane_mask_t wea;
    logic       regcea;
    data_t      douta;

    integer     seed;
    int         cycle_count = 0;
    string      cur_test;

    `include "spram_model.svh"

    spram_top #(
        .write_mode  (dut_mode),
        .read_latency(tb_latency)
    ) spram_top_inst (
        .clka  (clka),
        .rsta  (rsta),
        .ena   (ena),
        .addra (addra),
        .dina  (dina),
        .wea   (wea),
        .regcea(regcea),
        .douta (douta)
    );

    initial begin
        clka = 1'b0;
        forever #2 clka = ~clka;                           // 4 ns period
    end

    always @(posedge clka) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // Fill word built from every address bit
    function automatic data_t pattern_word(addr_t a);
        return {8'ha5, 2'b00, a, 2'b11, ~a, 2'b01, a};
    endfunction

    // Drives one cycle, steps the model over the same edge, checks douta
    task automatic drive_cycle(input logic en, input addr_t a, input data_t d,
                               input lane_mask_t we, input logic ce);
        ena    = en;
        addra  = a;
        dina   = d;
        wea    = we;
        regcea = ce;
        model_edge(en, a, d, we, ce);
        @(posedge clka);
        #1;
        check_word(cur_test, model_out, douta);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, '0, 1'b1);
    endtask

    task automatic write_word(input addr_t a, input data_t d, input lane_mask_t we);
        drive_cycle(1'b1, a, d, we, 1'b1);
    endtask

    // Read request, then wait out the latency
    task automatic read_check(input addr_t a, input data_t expected);
        drive_cycle(1'b1, a, '0, '0, 1'b1);
        idle_cycles(tb_latency - 1);
        check_word(cur_test, expected, douta);
    endtask

    task automatic pulse_reset(input int n);
        ena    = 1'b0;
        wea    = '0;
        regcea = 1'b0;
        rsta   = 1'b1;
        model_reset();
        repeat (n) @(posedge clka);
        #1;
        rsta = 1'b0;
    endtask

    task automatic zero_after_reset();
        cur_test = "reset_state";
        check_word(cur_test, '0, douta);
        read_check(6'd63, '0);                             // Never written
    endtask

    task automatic byte_lane_writes();
        data_t       first;
        data_t       second;
        lane_mask_t  mask;
        logic [31:0] rnd;
        data_t       expected [num_lane_words];
        cur_test = "byte_lanes";
        for (int i = 0; i < num_lane_words; i++) begin
            first  = $random(seed);
            second = $random(seed);
            rnd    = $random(seed);
            mask   = rnd[num_lanes-1:0];
            write_word(addr_t'(4 * i + 2), first, '1);
            write_word(addr_t'(4 * i + 2), second, mask);
            expected[i] = merge_lanes(first, second, mask);
        end
        for (int i = 0; i < num_lane_words; i++) begin
            read_check(addr_t'(4 * i + 2), expected[i]);
        end
    endtask

    task automatic write_collision();
        data_t      old_word;
        data_t      other_word;
        data_t      new_word;
        lane_mask_t mask;
        data_t      expected;
        cur_test   = "collision";
        old_word   = 32'h1122_3344;
        other_word = 32'hdead_beef;
        new_word   = 32'haabb_ccdd;
        mask       = 4'b0101;
        write_word(6'd50, old_word, '1);
        write_word(6'd51, other_word, '1);
        drive_cycle(1'b1, 6'd51, '0, '0, 1'b1);           // Last read before the write
        write_word(6'd50, new_word, mask);
        idle_cycles(tb_latency - 1);
        case (tb_write_mode)
            1:       expected = merge_lanes(old_word, new_word, mask);
            2:       expected = other_word;
            default: expected = old_word;
        endcase
        check_word(cur_test, expected, douta);
        read_check(6'd50, merge_lanes(old_word, new_word, mask));
    endtask

    task automatic back_to_back_reads();
        cur_test = "back_to_back";
        for (int i = 0; i < 4; i++) begin
            write_word(addr_t'(10 + i), pattern_word(addr_t'(10 + i)), '1);
        end
        for (int k = 0; k < 4 + tb_latency - 1; k++) begin
            if (k < 4) begin
                drive_cycle(1'b1, addr_t'(10 + k), '0, '0, 1'b1);
            end else begin
                idle_cycles(1);
            end
            if (k >= tb_latency - 1) begin
                check_word(cur_test, pattern_word(addr_t'(10 + k - (tb_latency - 1))), douta);
            end
        end
    endtask

    task automatic regcea_stall();
        cur_test = "regcea_low";
        for (int i = 0; i < 4; i++) begin
            write_word(addr_t'(20 + i), pattern_word(addr_t'(20 + i)), '1);
        end
        read_check(6'd20, pattern_word(6'd20));
        for (int i = 1; i < 4; i++) begin
            drive_cycle(1'b1, addr_t'(20 + i), '0, '0, 1'b0);
            check_word(cur_test, pattern_word(6'd20), douta);
        end
        // Word 21 went past the stalled final stage
        idle_cycles(1);
        check_word(cur_test, pattern_word(6'd22), douta);
        idle_cycles(1);
        check_word(cur_test, pattern_word(6'd23), douta);
    endtask

    task automatic memory_survives_reset();
        cur_test = "reset_keeps_memory";
        for (int i = 0; i < 4; i++) begin
            write_word(addr_t'(30 + i), pattern_word(addr_t'(30 + i)), '1);
        end
        read_check(6'd33, pattern_word(6'd33));            // Non-zero output before reset
        pulse_reset(1);
        check_word(cur_test, '0, douta);
        for (int i = 0; i < 4; i++) begin
            read_check(addr_t'(30 + i), pattern_word(addr_t'(30 + i)));
        end
    endtask

    initial begin
        seed   = 32'hcdc8;
        ena    = 1'b0;
        addra  = '0;
        dina   = '0;
        wea    = '0;
        regcea = 1'b0;
        rsta   = 1'b1;
        pulse_reset(3);
        zero_after_reset();
        byte_lane_writes();
        write_collision();
        back_to_back_reads();
        regcea_stall();
        memory_survives_reset();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: verilog/spram_top.sv
// ----------------------------------------------------------
// Single-port RAM with byte-lane writes. write_mode picks
// the collision behaviour, read_latency (1 to 4) the number
// of cycles from request to douta; regcea gates the last.
// ----------------------------------------------------------

`timescale 1ns/1ps

module spram_top #(
    parameter spram_pkg::write_mode_e write_mode   = spram_pkg::wm_read_first,
    parameter int                     read_latency = 2
) (
    input  logic                  clka,
    input  logic                  rsta,
    input  logic                  ena,
    input  spram_pkg::addr_t      addra,
    input  spram_pkg::data_t      dina,
    input  spram_pkg::lane_mask_t wea,
    input  logic                  regcea,
    output spram_pkg::data_t      douta
);

    import spram_pkg::*;

    // Decoded request
    lane_mask_t lane_wr;
    logic       rd_capture;
    lane_mask_t bypass_lanes;
    addr_t      addr;

    data_t      rd_word;                                   // First read register

    // Mode handling stays in the controller
    spram_port_ctrl #(
        .write_mode  (write_mode)
    ) spram_port_ctrl_inst (
        .ena         (ena),
        .addra       (addra),
        .wea         (wea),
        .lane_wr     (lane_wr),
        .rd_capture  (rd_capture),
        .bypass_lanes(bypass_lanes),
        .addr        (addr)
    );

    spram_array spram_array_inst (
        .clka        (clka),
        .rsta        (rsta),
        .addr        (addr),
        .din         (dina),
        .lane_wr     (lane_wr),
        .rd_capture  (rd_capture),
        .bypass_lanes(bypass_lanes),
        .rd_word     (rd_word)
    );

    // Remaining latency after the first read register
    spram_out_pipe #(
        .read_latency(read_latency)
    ) spram_out_pipe_inst (
        .clka        (clka),
        .rsta        (rsta),
        .rd_word     (rd_word),
        .regcea      (regcea),
        .douta       (douta)
    );

endmodule

// File: verilog/spram_out_pipe.sv
// ----------------------------------------------------------
// Read pipeline of the single-port RAM. Adds the stages that
// follow the first read register; regcea enables only the
// last one, earlier stages advance on every edge.
// ----------------------------------------------------------

`timescale 1ns/1ps

module spram_out_pipe #(
    parameter int read_latency = 2
) (
    input  logic             clka,
    input  logic             rsta,
    input  spram_pkg::data_t rd_word,
    input  logic             regcea,
    output spram_pkg::data_t douta
);

    import spram_pkg::*;

    // Build-time range check
    if ((read_latency < 1) || (read_latency > max_read_latency)) begin : g_bad_latency
        $error("spram_out_pipe: read_latency %0d outside 1..%0d",
               read_latency, max_read_latency);
    end

    if (read_latency == 1) begin : g_direct
        // First read register is the output, regcea plays no part
        assign douta = rd_word;
    end else begin : g_stages
        localparam int num_stages = read_latency - 1;
        localparam int last_stage = num_stages - 1;

        data_t stage [num_stages];

        for (genvar k = 0; k < num_stages; k++) begin : g_stage
            data_t stage_in;                               // Data arriving at this stage

            if (k == 0) begin : g_from_array
                assign stage_in = rd_word;
            end else begin : g_from_prev
                assign stage_in = stage[k-1];
            end

            if (k == last_stage) begin : g_final
                // Output stage, loads only with the clock enable
                always_ff @(posedge clka or posedge rsta) begin
                    if (rsta) begin
                        stage[k] <= read_reset_value;
                    end else if (regcea) begin
                        stage[k] <= stage_in;
                    end
                end
            end else begin : g_free
                always_ff @(posedge clka or posedge rsta) begin
                    if (rsta) begin
                        stage[k] <= read_reset_value;
                    end else begin
                        stage[k] <= stage_in;          // Never stalls
                    end
                end
            end
        end

        assign douta = stage[last_stage];

        // Output frozen for an edge sampled with regcea low
        a_douta_hold: assert property (
            @(posedge clka) disable iff (rsta)
            !regcea |=> $stable(douta)
        ) else $error("spram_out_pipe: douta changed while regcea was low");
    end

endmodule

// File: verilog/spram_array.sv
// ----------------------------------------------------------
// Storage of the single-port RAM. Writes the strobed byte
// lanes of din and loads the first read register, taking
// each lane from din or from the stored word.
// ----------------------------------------------------------

`timescale 1ns/1ps

module spram_array (
    input  logic                  clka,
    input  logic                  rsta,
    input  spram_pkg::addr_t      addr,
    input  spram_pkg::data_t      din,
    input  spram_pkg::lane_mask_t lane_wr,
    input  logic                  rd_capture,
    input  spram_pkg::lane_mask_t bypass_lanes,
    output spram_pkg::data_t      rd_word
);

    import spram_pkg::*;

    // Word storage, starts at zero and is never reset
    data_t mem [mem_depth] = '{default: '0};

    data_t mem_word;                                       // Stored word at addr, before this edge
    data_t rd_next;                                        // Value the read register would load

    assign mem_word = mem[addr];

    // Byte-lane write
    always_ff @(posedge clka) begin
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_wr[i]) begin
                mem[addr][i*byte_width +: byte_width] <= din[i*byte_width +: byte_width];
            end
        end
    end

    // Per-lane select between write data and stored data
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (bypass_lanes[i]) begin
                rd_next[i*byte_width +: byte_width] = din[i*byte_width +: byte_width];
            end else begin
                rd_next[i*byte_width +: byte_width] = mem_word[i*byte_width +: byte_width];
            end
        end
    end

    // First read register
    always_ff @(posedge clka or posedge rsta) begin
        if (rsta) begin
            rd_word <= read_reset_value;
        end else if (rd_capture) begin
            rd_word <= rd_next;
        end
    end

    // Register holds through any cycle without a capture request
    a_rd_word_hold: assert property (
        @(posedge clka) disable iff (rsta)
        !rd_capture |=> $stable(rd_word)
    ) else $error("spram_array: rd_word changed without rd_capture");

endmodule

// File: verilog/spram_port_ctrl.sv
// ----------------------------------------------------------
// Request decoder of the single-port RAM. Turns ena and wea
// into lane strobes, a read-capture enable and bypass lanes
// according to the write mode chosen at build time.
// ----------------------------------------------------------

`timescale 1ns/1ps

module spram_port_ctrl #(
    parameter spram_pkg::write_mode_e write_mode = spram_pkg::wm_read_first
) (
    input  logic                  ena,
    input  spram_pkg::addr_t      addra,
    input  spram_pkg::lane_mask_t wea,
    output spram_pkg::lane_mask_t lane_wr,
    output logic                  rd_capture,
    output spram_pkg::lane_mask_t bypass_lanes,
    output spram_pkg::addr_t      addr
);

    import spram_pkg::*;

    logic any_wr;                                          // At least one lane strobed

    assign any_wr = ena && (|wea);
    assign addr   = addra;                                 // Array uses the request address as is

    // Lane strobes only while the port is enabled
    assign lane_wr = ena ? wea : '0;

    // Mode rules for the first read register and the bypass mux
    always_comb begin
        case (write_mode)
            wm_write_first: begin
                rd_capture   = ena;
                bypass_lanes = lane_wr;                    // New bytes go straight to the output
            end
            wm_no_change: begin
                rd_capture   = ena && !any_wr;             // Output keeps the last read
                bypass_lanes = '0;
            end
            default: begin
                // Read-first, the stored word is sampled before the write lands
                rd_capture   = ena;
                bypass_lanes = '0;
            end
        endcase
    end

endmodule

// File: verilog/spram_pkg.sv
// ----------------------------------------------------------
// Shared widths, depth, reset value and write-mode type of
// the single-port RAM. Modules import it inside their body.
// ----------------------------------------------------------

package spram_pkg;

    // Word and lane geometry
    localparam int data_width = 32;
    localparam int byte_width = 8;                         // One write lane
    localparam int num_lanes  = data_width / byte_width;

    // Array size
    localparam int mem_depth  = 64;
    localparam int addr_width = $clog2(mem_depth);

    // Read pipeline limit, counted from the request edge
    localparam int max_read_latency = 4;

    // Common types
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [num_lanes-1:0]  lane_mask_t;

    // Value of every read register after rsta
    localparam data_t read_reset_value = '0;

    // Read behaviour when a write hits the same port
    typedef enum logic [1:0] {
        wm_read_first,                                     // Old word to the output
        wm_write_first,                                    // Merged word to the output
        wm_no_change                                       // Output holds during writes
    } write_mode_e;

endpackage
